// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_mips_cpu
FILELIST := mips_cpu.f
LOG      := sim.log
PASS_MSG := Simulation completed successfully

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== alu.sv ====
// the alu computes 32-bit add, sub, and, or and signed set-less-than with a zero flag
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic              [31:0] a,
  input  logic              [31:0] b,
  input  mips_pkg::alu_op_e        op,
  output logic              [31:0] result,
  output logic                     zero
);
  import mips_pkg::*;

  always_comb begin
    case (op)
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: result = a + b;
    endcase
    zero = (result == 32'd0);  // branches use sub, so zero means the operands are equal
  end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
// data_mem: word-addressed data RAM, synchronous write, asynchronous read, cleared on reset
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
  parameter int DMEM_WORDS = 64
) (
  input  logic        clock,
  input  logic        rst,
  input  logic        write_en,
  input  logic [31:0] addr,
  input  logic [31:0] write_data,
  output logic [31:0] read_data
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic [31:0]   mem [DMEM_WORDS];
  logic [AW-1:0] index;

  assign index = addr[AW-1:0];  // upper address bits wrap

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int n = 0; n < DMEM_WORDS; n++) begin
        mem[n] <= '0;
      end
    end else if (write_en) begin
      mem[index] <= write_data;
    end
  end

  assign read_data = mem[index];

endmodule

`default_nettype wire

// ==== decode_control.sv ====
// decode_control: instruction field split, main control, ALU operation and immediate extension
`timescale 1ns/1ps
`default_nettype none

module decode_control (
  input  logic            run,
  input  logic [31:0]     instr,
  output mips_pkg::ctrl_t ctrl,
  output logic [4:0]      rs_addr,
  output logic [4:0]      rt_addr,
  output logic [4:0]      rd_addr,
  output logic [31:0]     imm,
  output logic [25:0]     target
);
  import mips_pkg::*;

  instr_u ins;

  assign ins     = instr;
  assign rs_addr = ins.r.rs;
  assign rt_addr = ins.r.rt;
  assign rd_addr = ins.r.rd;
  assign target  = {ins.i.rs, ins.i.rt, ins.i.imm};

  always_comb begin
    ctrl = '0;  // no writes, no branch, sequential pc
    case (ins.i.opcode)
      OP_RTYPE: begin
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = DST_RD;
        case (ins.r.funct)
          FN_ADD: ctrl.alu_op = ALU_ADD;
          FN_SUB: ctrl.alu_op = ALU_SUB;
          FN_AND: ctrl.alu_op = ALU_AND;
          FN_OR:  ctrl.alu_op = ALU_OR;
          FN_SLT: ctrl.alu_op = ALU_SLT;
          FN_JR: begin
            ctrl.reg_write = 1'b0;
            ctrl.jump      = JMP_REG;
          end
          default: ctrl = '0;  // unknown funct falls through as a no-op
        endcase
      end
      OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_imm   = 1'b1;
        ctrl.zero_ext  = (ins.i.opcode == OP_ANDI) || (ins.i.opcode == OP_ORI);
        case (ins.i.opcode)
          OP_SLTI: ctrl.alu_op = ALU_SLT;
          OP_ANDI: ctrl.alu_op = ALU_AND;
          OP_ORI:  ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_ADD;
        endcase
      end
      OP_LW: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_imm   = 1'b1;
        ctrl.wb_sel    = WB_MEM;
      end
      OP_SW: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_imm   = 1'b1;
      end
      OP_BEQ, OP_BNE: begin
        ctrl.branch = (ins.i.opcode == OP_BEQ) ? BR_EQ : BR_NE;
        ctrl.alu_op = ALU_SUB;  // zero flag compares rs with rt
      end
      OP_J: ctrl.jump = JMP_TARGET;
      OP_JAL: begin
        ctrl.jump      = JMP_TARGET;
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = DST_RA;
        ctrl.wb_sel    = WB_PC1;
      end
      default: ctrl = '0;
    endcase
    // nothing is written while the loader owns the core
    ctrl.reg_write = ctrl.reg_write & run;
    ctrl.mem_write = ctrl.mem_write & run;
  end

  assign imm = ctrl.zero_ext ? {16'h0000, ins.i.imm} : {{16{ins.i.imm[15]}}, ins.i.imm};

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
// fetch_unit: program counter, next-address selection and loadable instruction memory
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter int IMEM_WORDS = 64
) (
  input  logic            clock,
  input  logic            rst,
  input  logic            run,
  input  logic            load_en,
  input  logic [31:0]     load_addr,
  input  logic [31:0]     load_data,
  input  mips_pkg::ctrl_t ctrl,
  input  logic [31:0]     imm,
  input  logic [25:0]     target,
  input  logic [31:0]     rs_value,
  input  logic            alu_zero,
  output logic [31:0]     instr,
  output logic [31:0]     pc,
  output logic [31:0]     pc_plus1
);
  import mips_pkg::*;

  localparam int AW = $clog2(IMEM_WORDS);

  logic [31:0]   imem [IMEM_WORDS];
  logic [AW-1:0] pc_q;  // only the index bits are kept, so the pc wraps with the memory
  logic          branch_taken;
  logic [31:0]   seq_next;
  logic [31:0]   pc_next;

  // loader port, the address wraps within the memory
  always_ff @(posedge clock) begin
    if (load_en) begin
      imem[load_addr[AW-1:0]] <= load_data;
    end
  end

  assign instr    = imem[pc_q];
  assign pc       = {{(32 - AW){1'b0}}, pc_q};
  assign pc_plus1 = pc + 32'd1;  // not wrapped here, jal links this full value

  always_comb begin
    case (ctrl.branch)
      BR_EQ:   branch_taken = alu_zero;
      BR_NE:   branch_taken = !alu_zero;
      default: branch_taken = 1'b0;
    endcase
    seq_next = branch_taken ? pc_plus1 + imm : pc_plus1;
    case (ctrl.jump)
      JMP_TARGET: pc_next = {6'd0, target};
      JMP_REG:    pc_next = rs_value;  // jr treats the register as a word index
      default:    pc_next = seq_next;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst || !run) begin
      pc_q <= '0;  // held at the first word while loading
    end else begin
      pc_q <= pc_next[AW-1:0];
    end
  end

  // the loader must only write while the core is stopped
  load_while_run_a: assert property (@(posedge clock) disable iff (rst) !(run && load_en))
    else $error("instruction load while running");

endmodule

`default_nettype wire

// ==== mips_cpu.f ====
mips_pkg.sv
alu.sv
data_mem.sv
reg_file.sv
decode_control.sv
fetch_unit.sv
mips_cpu.sv
tb_mips_cpu.sv

// ==== mips_cpu.sv ====
// mips_cpu: single-cycle MIPS32 subset core with an instruction loader port
`timescale 1ns/1ps
`default_nettype none

module mips_cpu #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic        clock,
  input  logic        rst,
  input  logic        run,        // low while the program is being loaded
  input  logic        load_en,
  input  logic [31:0] load_addr,
  input  logic [31:0] load_data,
  output logic [31:0] output_pc,  // word index of the instruction about to execute
  output logic [31:0] output_t0
);
  import mips_pkg::*;

  ctrl_t       ctrl;
  logic [31:0] instr;
  logic [31:0] pc_plus1;
  logic [4:0]  rs_addr;
  logic [4:0]  rt_addr;
  logic [4:0]  rd_addr;
  logic [4:0]  write_addr;
  logic [31:0] imm;
  logic [25:0] target;
  logic [31:0] rs_value;
  logic [31:0] rt_value;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        alu_zero;
  logic [31:0] mem_data;
  logic [31:0] write_data;

  fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (
    .clock(clock),
    .rst(rst),
    .run(run),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .ctrl(ctrl),
    .imm(imm),
    .target(target),
    .rs_value(rs_value),
    .alu_zero(alu_zero),
    .instr(instr),
    .pc(output_pc),
    .pc_plus1(pc_plus1)
  );

  decode_control decode_i (
    .run(run),
    .instr(instr),
    .ctrl(ctrl),
    .rs_addr(rs_addr),
    .rt_addr(rt_addr),
    .rd_addr(rd_addr),
    .imm(imm),
    .target(target)
  );

  always_comb begin
    case (ctrl.dst_sel)
      DST_RD:  write_addr = rd_addr;
      DST_RA:  write_addr = 5'd31;
      default: write_addr = rt_addr;
    endcase
    case (ctrl.wb_sel)
      WB_MEM:  write_data = mem_data;
      WB_PC1:  write_data = pc_plus1;  // link address for jal
      default: write_data = alu_result;
    endcase
  end

  reg_file regs_i (
    .clock(clock),
    .rst(rst),
    .write_en(ctrl.reg_write),
    .rs_addr(rs_addr),
    .rt_addr(rt_addr),
    .write_addr(write_addr),
    .write_data(write_data),
    .rs_value(rs_value),
    .rt_value(rt_value),
    .output_t0(output_t0)
  );

  assign alu_b = ctrl.alu_imm ? imm : rt_value;

  alu alu_i (
    .a(rs_value),
    .b(alu_b),
    .op(ctrl.alu_op),
    .result(alu_result),
    .zero(alu_zero)
  );

  data_mem #(.DMEM_WORDS(DMEM_WORDS)) dmem_i (
    .clock(clock),
    .rst(rst),
    .write_en(ctrl.mem_write),
    .addr(alu_result),          // ALU result is already a word address
    .write_data(rt_value),
    .read_data(mem_data)
  );

endmodule

`default_nettype wire

// ==== mips_pkg.sv ====
// mips_pkg: shared instruction layout, opcode/funct encodings and control types for the CPU
`default_nettype none

package mips_pkg;

  // one instruction word, seen either with R-type fields or with I-type fields
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;  // j-type target is rs, rt and imm taken together
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_SLTI  = 6'h0a;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  localparam logic [5:0] FN_JR  = 6'h08;
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  // the zero value of each select is the plain case, so an all-zero struct is a no-op
  localparam logic [1:0] DST_RT = 2'd0;
  localparam logic [1:0] DST_RD = 2'd1;
  localparam logic [1:0] DST_RA = 2'd2;  // register 31 for jal

  localparam logic [1:0] WB_ALU = 2'd0;
  localparam logic [1:0] WB_MEM = 2'd1;
  localparam logic [1:0] WB_PC1 = 2'd2;

  localparam logic [1:0] BR_NONE = 2'd0;
  localparam logic [1:0] BR_EQ   = 2'd1;
  localparam logic [1:0] BR_NE   = 2'd2;

  localparam logic [1:0] JMP_SEQ    = 2'd0;
  localparam logic [1:0] JMP_TARGET = 2'd1;
  localparam logic [1:0] JMP_REG    = 2'd2;

  typedef struct packed {
    logic       reg_write;
    logic [1:0] dst_sel;
    logic [1:0] wb_sel;
    logic       alu_imm;
    logic       zero_ext;
    logic       mem_write;
    logic [1:0] branch;
    logic [1:0] jump;
    alu_op_e    alu_op;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== reg_file.sv ====
// the reg_file holds 32 words with two asynchronous reads, one write port and the t0 output
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic        clock,
  input  logic        rst,
  input  logic        write_en,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data,
  output logic [31:0] rs_value,
  output logic [31:0] rt_value,
  output logic [31:0] output_t0
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int n = 0; n < 32; n++) begin
        regs[n] <= '0;
      end
    end else if (write_en && write_addr != 5'd0) begin
      regs[write_addr] <= write_data;  // writes to register zero are dropped
    end
  end

  assign rs_value  = regs[rs_addr];
  assign rt_value  = regs[rt_addr];
  assign output_t0 = regs[8];

  // register zero reads as zero only because reset clears it and writes skip it
  r0_zero_a: assert property (@(posedge clock) disable iff (rst)
    (rs_addr == 5'd0) |-> (rs_value == '0))
    else $error("register zero is not zero");

endmodule

`default_nettype wire

// ==== tb_mips_cpu.sv ====
// tb_mips_cpu: random program testbench for the single-cycle MIPS core with a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu;
  import mips_pkg::*;

  localparam int IMEM_WORDS   = 64;
  localparam int DMEM_WORDS   = 64;
  localparam int IMEM_AW      = $clog2(IMEM_WORDS);
  localparam int DMEM_AW      = $clog2(DMEM_WORDS);
  localparam int CLOCK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  localparam int RUN_CYCLES   = 200;
  localparam int NUM_TESTS    = 5;
  localparam int WATCHDOG_CYCLES =
    NUM_TESTS * (RESET_CYCLES + IMEM_WORDS + RUN_CYCLES) + RESET_CYCLES + 200;

  logic        clock;
  logic        rst;
  logic        run;
  logic        load_en;
  logic [31:0] load_addr;
  logic [31:0] load_data;
  logic [31:0] output_pc;
  logic [31:0] output_t0;

  // reference model state
  logic [31:0]        prog [IMEM_WORDS];
  logic [31:0]        mregs [32];
  logic [31:0]        mdmem [DMEM_WORDS];
  logic [IMEM_AW-1:0] mpc;
  logic [31:0]        lfsr_state = 32'hcbb4;

  mips_cpu #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) dut_i (
    .clock(clock),
    .rst(rst),
    .run(run),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .output_pc(output_pc),
    .output_t0(output_t0)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  task automatic report_failure(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      report_failure($sformatf("error: %s is %h, expected %h", name, got, expected));
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    report_failure("timeout: the test sequence did not finish in the expected time");
  end

  // fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  // three out of four picks land on t0 to t3 so that t0 moves often
  function automatic logic [4:0] pick_reg();
    logic [4:0] r;
    if (rand_bits(2) != 32'd0) begin
      r = 5'd8 + 5'(rand_bits(2));
    end else begin
      r = 5'(rand_bits(5));
    end
    return r;
  endfunction

  function automatic logic [15:0] small_imm();
    logic [3:0] s;
    s = 4'(rand_bits(4));
    return {{12{s[3]}}, s};
  endfunction

  function automatic logic [15:0] any_imm();
    logic [15:0] v;
    if (rand_bits(1) == 32'd1) begin
      v = 16'(rand_bits(16));
    end else begin
      v = small_imm();
    end
    return v;
  endfunction

  function automatic logic [15:0] branch_offset();
    logic [15:0] off;
    off = small_imm();
    return (off == 16'hffff) ? 16'd2 : off;  // an offset of -1 would spin on itself
  endfunction

  function automatic logic [31:0] encode_r(logic [5:0] funct, logic [4:0] rs,
                                           logic [4:0] rt, logic [4:0] rd);
    instr_u w;
    w.r.opcode = OP_RTYPE;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    w.r.shamt  = 5'd0;
    w.r.funct  = funct;
    return w;
  endfunction

  function automatic logic [31:0] encode_i(logic [5:0] opcode, logic [4:0] rs,
                                           logic [4:0] rt, logic [15:0] imm);
    instr_u w;
    w.i.opcode = opcode;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = imm;
    return w;
  endfunction

  function automatic logic [31:0] illegal_word();
    logic [31:0] word;
    if (rand_bits(1) == 32'd1) begin
      word = {OP_RTYPE, 20'(rand_bits(20)), 6'h3f};  // R-type with a funct that means nothing
    end else begin
      word = {2'b11, 4'(rand_bits(4)), 26'(rand_bits(26))};  // opcodes 0x30 to 0x3f are unused
    end
    return word;
  endfunction

  function automatic logic [31:0] random_word();
    logic [3:0]  kind;
    logic [4:0]  dst;
    logic [4:0]  src1;
    logic [4:0]  src2;
    logic [4:0]  base;
    logic [31:0] word;
    kind = 4'(rand_bits(4));
    dst  = (rand_bits(3) == 32'd0) ? 5'd0 : pick_reg();  // some writes aim at register zero
    src1 = pick_reg();
    src2 = pick_reg();
    base = (rand_bits(1) == 32'd1) ? 5'd0 : src1;  // zero base makes addresses collide often
    case (kind)
      4'd0:  word = encode_r(FN_ADD, src1, src2, dst);
      4'd1:  word = encode_r(FN_SUB, src1, src2, dst);
      4'd2:  word = encode_r(FN_AND, src1, src2, dst);
      4'd3:  word = encode_r(FN_OR, src1, src2, dst);
      4'd4:  word = encode_r(FN_SLT, src1, src2, dst);
      4'd5:  word = encode_i(OP_ADDI, src1, dst, any_imm());
      4'd6:  word = encode_i(OP_ANDI, src1, dst, 16'(rand_bits(16)));
      4'd7:  word = encode_i(OP_ORI, src1, dst, 16'(rand_bits(16)));
      4'd8:  word = encode_i(OP_SLTI, src1, dst, any_imm());
      4'd9:  word = encode_i(OP_LW, base, dst, small_imm());
      4'd10: word = encode_i(OP_SW, base, src2, small_imm());
      4'd11: word = encode_i(OP_BEQ, src1, src2, branch_offset());
      4'd12: word = encode_i(OP_BNE, src1, src2, branch_offset());
      4'd13: word = {OP_J, 26'(rand_bits(26))};
      4'd14: begin
        if (rand_bits(1) == 32'd1) begin
          word = {OP_JAL, 26'(rand_bits(26))};
        end else if (rand_bits(1) == 32'd1) begin
          word = encode_r(FN_JR, 5'd31, 5'd0, 5'd0);  // return through the jal link
        end else begin
          word = encode_r(FN_JR, src1, 5'd0, 5'd0);
        end
      end
      default: word = illegal_word();
    endcase
    return word;
  endfunction

  function automatic logic [31:0] signed_less(logic [31:0] a, logic [31:0] b);
    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
  endfunction

  task automatic reset_model();
    for (int n = 0; n < 32; n++) begin
      mregs[n] = '0;
    end
    for (int n = 0; n < DMEM_WORDS; n++) begin
      mdmem[n] = '0;
    end
    mpc = '0;
  endtask

  // executes one instruction of the model, pc counts words and wraps with the memory
  task automatic model_step();
    logic [31:0] word;
    instr_u      w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic [31:0] val;
    logic [4:0]  dst;
    logic        wr;
    word    = prog[mpc];
    w       = word;
    a       = mregs[w.r.rs];
    b       = mregs[w.r.rt];
    sext    = {{16{w.i.imm[15]}}, w.i.imm};
    zext    = {16'h0000, w.i.imm};
    addr    = a + sext;
    next_pc = 32'(mpc) + 32'd1;
    val     = '0;
    dst     = w.i.rt;
    wr      = 1'b1;
    case (w.i.opcode)
      OP_RTYPE: begin
        dst = w.r.rd;
        case (w.r.funct)
          FN_ADD: val = a + b;
          FN_SUB: val = a - b;
          FN_AND: val = a & b;
          FN_OR:  val = a | b;
          FN_SLT: val = signed_less(a, b);
          FN_JR: begin
            wr      = 1'b0;
            next_pc = a;
          end
          default: wr = 1'b0;
        endcase
      end
      OP_ADDI: val = a + sext;
      OP_SLTI: val = signed_less(a, sext);
      OP_ANDI: val = a & zext;
      OP_ORI:  val = a | zext;
      OP_LW:   val = mdmem[addr[DMEM_AW-1:0]];
      OP_SW: begin
        wr = 1'b0;
        mdmem[addr[DMEM_AW-1:0]] = b;
      end
      OP_BEQ, OP_BNE: begin
        wr = 1'b0;
        if ((a == b) == (w.i.opcode == OP_BEQ)) begin
          next_pc = next_pc + sext;
        end
      end
      OP_J: begin
        wr      = 1'b0;
        next_pc = {6'd0, word[25:0]};
      end
      OP_JAL: begin
        dst     = 5'd31;
        val     = next_pc;  // link is the word after the jal
        next_pc = {6'd0, word[25:0]};
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) begin
      mregs[dst] = val;
    end
    mpc = next_pc[IMEM_AW-1:0];
  endtask

  task automatic apply_reset();
    @(posedge clock);
    rst     <= 1'b1;
    run     <= 1'b0;
    load_en <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    rst <= 1'b0;
    reset_model();
    @(negedge clock);
    check_value("output_pc", output_pc, 32'd0);
    check_value("output_t0", output_t0, 32'd0);
  endtask

  task automatic build_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      prog[i] = random_word();
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      @(posedge clock);
      load_en   <= 1'b1;
      load_addr <= 32'(i);
      load_data <= prog[i];
      @(negedge clock);
      check_value("output_pc", output_pc, 32'd0);  // pc stays parked while loading
    end
    @(posedge clock);
    load_en <= 1'b0;
    run     <= 1'b1;
    @(negedge clock);
    check_value("output_pc", output_pc, 32'd0);
  endtask

  task automatic execute_program();
    for (int c = 0; c < RUN_CYCLES; c++) begin
      @(posedge clock);
      model_step();
      @(negedge clock);
      check_value("output_pc", output_pc, 32'(mpc));
      check_value("output_t0", output_t0, mregs[8]);
    end
    @(posedge clock);
    run <= 1'b0;
  endtask

  initial begin
    rst       = 1'b1;
    run       = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    apply_reset();
    for (int t = 0; t < NUM_TESTS; t++) begin
      build_program();
      load_program();
      execute_program();
      apply_reset();  // each test leaves a cleared core behind
      $display("test %0d finished", t);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
